//--- project.f
mem_cfg_pkg.sv
mem_txn_pkg.sv
mem_rd_if.sv
mem_req_decode.sv
memory_dp.sv
mem_rsp_align.sv
mem_slave_top.sv
mem_slave_props.sv
tb_mem_slave.sv

//--- Makefile
TOP = tb_mem_slave
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f --Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_mem_slave.sv
//////////////////////////////
// testbench for the memory-mapped slave
// shadow byte memory, expected-read queue, data check
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mem_slave;

  localparam int ADDR_W     = 6;
  localparam int DEPTH      = 1 << ADDR_W;
  localparam int MAX_CYCLES = 3000;  // all six tests need well under 1000

  typedef logic [ADDR_W+1:0] addr_t;

  logic rd_clk, rst_n, req_valid, req_write;
  addr_t req_addr;
  mem_txn_pkg::size_t req_size;
  mem_cfg_pkg::data_t req_wdata, rsp_data;
  logic rsp_valid, req_err;

  logic [7:0] shadow [DEPTH][4];     // byte copy of the RAM
  mem_cfg_pkg::data_t exp_q [$];     // expected read data in issue order
  int seed, err_cnt, check_cnt, cycle_cnt;
  int test_num, pass_cnt, fail_test_cnt, fails_base;

  mem_slave_top #(.ADDR_W(ADDR_W)) i_dut (
    .rd_clk(rd_clk), .rst_n(rst_n), .req_valid(req_valid), .req_write(req_write),
    .req_addr(req_addr), .req_size(req_size), .req_wdata(req_wdata),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .req_err(req_err)
  );

  always #4 rd_clk = ~rd_clk;  // 8 ns period

  function automatic addr_t byte_addr(input int word, input int off);
    return addr_t'(word * 4 + off);
  endfunction

  // own counts plus failures of the bound protocol checks
  function automatic int total_fails();
    return err_cnt + int'(i_dut.i_props.fail_cnt);
  endfunction

  // apply the access rules to the shadow copy
  task automatic model(input logic wr, input addr_t addr, input mem_txn_pkg::size_t sz,
                       input mem_cfg_pkg::data_t wd);
    int w;
    int o;
    logic ok;
    w  = int'(addr[ADDR_W+1:2]);
    o  = int'(addr[1:0]);
    ok = (sz == mem_txn_pkg::SIZE_BYTE) || (sz == mem_txn_pkg::SIZE_HALF && o % 2 == 0) ||
         (sz == mem_txn_pkg::SIZE_WORD && o == 0);
    if (!ok) return;                       // rejected requests leave memory alone
    if (wr) begin
      if (sz == mem_txn_pkg::SIZE_BYTE) begin
        shadow[w][o] = wd[7:0];
      end else if (sz == mem_txn_pkg::SIZE_HALF) begin
        shadow[w][o]   = wd[7:0];
        shadow[w][o+1] = wd[15:8];
      end else begin
        for (int i = 0; i < 4; i++) shadow[w][i] = wd[i*8 +: 8];
      end
    end else if (sz == mem_txn_pkg::SIZE_BYTE) begin
      exp_q.push_back({24'd0, shadow[w][o]});              // zero-extended byte
    end else if (sz == mem_txn_pkg::SIZE_HALF) begin
      exp_q.push_back({16'd0, shadow[w][o+1], shadow[w][o]});
    end else begin
      exp_q.push_back({shadow[w][3], shadow[w][2], shadow[w][1], shadow[w][0]});
    end
  endtask

  // one strobed request driven 1 ns after the edge
  task automatic issue(input logic wr, input addr_t addr, input mem_txn_pkg::size_t sz,
                       input mem_cfg_pkg::data_t wd);
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_size  = sz;
    req_wdata = wd;
    model(wr, addr, sz, wd);
    @(posedge rd_clk);
    #1 req_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge rd_clk);
    #1;
  endtask

  // drain outstanding reads and report the test
  task automatic end_test(input string name);
    int errs;
    while (exp_q.size() != 0) @(posedge rd_clk);
    idle(4);
    errs = total_fails() - fails_base;
    test_num++;
    if (errs == 0) pass_cnt++;
    else fail_test_cnt++;
    $display("test %0d %s: %s, %0d errors", test_num, name, (errs == 0) ? "pass" : "fail", errs);
    fails_base = total_fails();
  endtask

  //////////////////////////////
  // data check
  //////////////////////////////

  always @(posedge rd_clk) begin
    if (rst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("response arrived with no read outstanding at %0t", $time);
        err_cnt++;
      end else begin
        check_cnt++;
        a_rsp_data: assert (rsp_data == exp_q[0]) else begin
          $display("ERROR %0t: rsp_data %h, expected %h", $time, rsp_data, exp_q[0]);
          err_cnt++;
        end
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge rd_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    int r;
    rd_clk = 1'b0;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    req_size = mem_txn_pkg::SIZE_BYTE;
    req_wdata = '0;
    seed = 32'h7c03b0aa;
    repeat (6) begin                     // random requests while in reset
      @(posedge rd_clk);
      #1;
      r = $random(seed);
      req_valid = 1'b1;
      req_write = r[0];
      req_addr  = addr_t'(r[ADDR_W+3:2]);
      req_size  = mem_txn_pkg::size_t'(r[31:30]);
      req_wdata = $random(seed);
    end
    @(posedge rd_clk);
    #1 req_valid = 1'b0;
    repeat (3) @(posedge rd_clk);        // quiet edges before release
    #1 rst_n = 1'b1;
    idle(2);

    for (int w = 0; w < DEPTH; w++) begin
      issue(1'b1, byte_addr(w, 0), mem_txn_pkg::SIZE_WORD, $random(seed));
    end
    for (int w = 0; w < DEPTH; w++) issue(1'b0, byte_addr(w, 0), mem_txn_pkg::SIZE_WORD, '0);
    end_test("word fill");

    for (int o = 0; o < 4; o++) begin    // one lane per word and its merged word
      issue(1'b1, byte_addr(8 + o, o), mem_txn_pkg::SIZE_BYTE, $random(seed));
      issue(1'b0, byte_addr(8 + o, 0), mem_txn_pkg::SIZE_WORD, '0);
    end
    for (int o = 0; o < 4; o += 2) begin
      issue(1'b1, byte_addr(12 + o, o), mem_txn_pkg::SIZE_HALF, $random(seed));
      issue(1'b0, byte_addr(12 + o, 0), mem_txn_pkg::SIZE_WORD, '0);
    end
    end_test("partial writes");

    for (int w = 8; w < 16; w++) begin
      for (int o = 0; o < 4; o++) begin
        issue(1'b0, byte_addr(w, o), mem_txn_pkg::SIZE_BYTE, '0);
        if (o % 2 == 0) issue(1'b0, byte_addr(w, o), mem_txn_pkg::SIZE_HALF, '0);
      end
    end
    end_test("partial reads");

    issue(1'b1, byte_addr(20, 0), mem_txn_pkg::SIZE_WORD, $random(seed));
    issue(1'b0, byte_addr(20, 0), mem_txn_pkg::SIZE_WORD, '0);   // read after write
    issue(1'b1, byte_addr(21, 3), mem_txn_pkg::SIZE_BYTE, $random(seed));
    issue(1'b0, byte_addr(21, 3), mem_txn_pkg::SIZE_BYTE, '0);
    for (int w = 22; w < 30; w++) issue(1'b0, byte_addr(w, 0), mem_txn_pkg::SIZE_WORD, '0);
    end_test("back to back");

    for (int o = 0; o < 4; o++) begin    // every illegal size and offset
      if (o % 2 == 1) issue(1'b1, byte_addr(30, o), mem_txn_pkg::SIZE_HALF, $random(seed));
      if (o != 0) issue(1'b1, byte_addr(30, o), mem_txn_pkg::SIZE_WORD, $random(seed));
      issue(1'(o % 2), byte_addr(30, o), mem_txn_pkg::size_t'(3), $random(seed));
    end
    issue(1'b0, byte_addr(30, 0), mem_txn_pkg::SIZE_WORD, '0);
    end_test("illegal requests");

    repeat (400) begin
      r = $random(seed);
      issue(r[0], addr_t'(r[ADDR_W+3:2]), mem_txn_pkg::size_t'(r[31:30]), $random(seed));
      if (r[1] && r[4]) idle(1);          // occasional gap
    end
    end_test("random mix");

    $display("tests %0d, passed %0d, failed %0d, data checks %0d, errors %0d",
             test_num, pass_cnt, fail_test_cnt, check_cnt, total_fails());
    if (fail_test_cnt == 0 && total_fails() == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_slave_props.sv
//////////////////////////////
// protocol checks, bound to the slave top
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_slave_props #(
  parameter int ADDR_W = 10
) (
  input wire                rd_clk,
  input wire                rst_n,
  input wire                req_valid,
  input wire                req_write,
  input wire [ADDR_W+1:0]   req_addr,
  input mem_txn_pkg::size_t req_size,
  input wire                rsp_valid,
  input wire                req_err,
  input mem_cfg_pkg::be_t   wr_be,
  input wire                rd_en
);

  int unsigned fail_cnt = 0;  // read by the testbench
  logic legal;

  always_comb begin
    case (req_size)
      mem_txn_pkg::SIZE_BYTE: legal = 1'b1;
      mem_txn_pkg::SIZE_HALF: legal = ~req_addr[0];          // even offset
      mem_txn_pkg::SIZE_WORD: legal = (req_addr[1:0] == 2'd0);
      default:                legal = 1'b0;
    endcase
  end

  // response set at the second edge, seen at the third sample
  a_rd_lat: assert property (@(posedge rd_clk) disable iff (!rst_n)
    $past(req_valid && legal && !req_write, 3) |-> rsp_valid)
    else begin $error("read strobe got no response two edges later"); fail_cnt++; end

  a_no_stray: assert property (@(posedge rd_clk) disable iff (!rst_n)
    rsp_valid |-> $past(req_valid && legal && !req_write, 3))
    else begin $error("response without a matching read"); fail_cnt++; end

  a_err: assert property (@(posedge rd_clk) disable iff (!rst_n)
    $past(req_valid && !legal) |-> req_err)
    else begin $error("illegal request raised no error"); fail_cnt++; end

  a_excl: assert property (@(posedge rd_clk) disable iff (!rst_n)
    $onehot0({req_err, |wr_be, rd_en}))
    else begin $error("more than one strobe active"); fail_cnt++; end

  a_rst: assert property (@(posedge rd_clk)
    (!rst_n && $past(!rst_n)) |-> (!req_err && !rsp_valid && wr_be == '0 && !rd_en))
    else begin $error("strobe active during reset"); fail_cnt++; end

endmodule

bind mem_slave_top mem_slave_props #(.ADDR_W(ADDR_W)) i_props (
  .rd_clk(rd_clk), .rst_n(rst_n), .req_valid(req_valid), .req_write(req_write),
  .req_addr(req_addr), .req_size(req_size), .rsp_valid(rsp_valid),
  .req_err(req_err), .wr_be(wr_be), .rd_en(rd_bus.rd_en)
);

`default_nettype wire

//--- mem_slave_top.sv
//////////////////////////////
// memory-mapped slave top: decoder, RAM, aligner
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_slave_top #(
  parameter int ADDR_W = 10   // word address width
) (
  input  wire                rd_clk,
  input  wire                rst_n,
  input  wire                req_valid,
  input  wire                req_write,
  input  wire [ADDR_W+1:0]   req_addr,    // byte address
  input  mem_txn_pkg::size_t req_size,
  input  mem_cfg_pkg::data_t req_wdata,
  output logic               rsp_valid,
  output mem_cfg_pkg::data_t rsp_data,
  output logic               req_err
);

  //////////////////////////////
  // internal nets
  //////////////////////////////

  mem_cfg_pkg::be_t   wr_be;
  logic [ADDR_W-1:0]  wr_addr;
  mem_cfg_pkg::data_t wr_data;
  mem_cfg_pkg::data_t rd_data;  // RAM output to aligner

  mem_rd_if #(.ADDR_W(ADDR_W)) rd_bus ();

  //////////////////////////////
  // instances
  //////////////////////////////

  mem_req_decode #(.ADDR_W(ADDR_W)) i_decode (
    .rd_clk    (rd_clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_size  (req_size),
    .req_wdata (req_wdata),
    .req_err   (req_err),
    .wr_be     (wr_be),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd        (rd_bus)
  );

  memory_dp #(.ADDR_W(ADDR_W)) i_ram (
    .rd_clk  (rd_clk),
    .wr_be   (wr_be),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd      (rd_bus),
    .rd_data (rd_data)
  );

  mem_rsp_align i_align (
    .rd_clk    (rd_clk),
    .rst_n     (rst_n),
    .rd_data   (rd_data),
    .rd        (rd_bus),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

endmodule

`default_nettype wire

//--- mem_rsp_align.sv
//////////////////////////////
// response side: sideband delay, lane select,
// zero extension, response strobe
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_rsp_align (
  input  wire                rd_clk,
  input  wire                rst_n,
  input  mem_cfg_pkg::data_t rd_data,   // RAM word, one edge after rd_en
  mem_rd_if.align            rd,
  output logic               rsp_valid,
  output mem_cfg_pkg::data_t rsp_data
);

  //////////////////////////////
  // sideband stage
  //////////////////////////////

  logic                 en_q;
  mem_txn_pkg::size_t   size_q;
  mem_txn_pkg::offset_t off_q;

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q <= 1'b0;
    end else begin
      en_q <= rd.rd_en;   // lines up with rd_data
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd.rd_en) begin
      size_q <= rd.rd_size;
      off_q  <= rd.rd_offset;
    end
  end

  //////////////////////////////
  // lane select
  //////////////////////////////

  mem_cfg_pkg::data_t shifted;
  mem_cfg_pkg::data_t sel_data;

  assign shifted = rd_data >> {off_q, 3'b000};  // addressed byte down to lane 0

  always_comb begin
    case (size_q)
      mem_txn_pkg::SIZE_BYTE: sel_data = mem_cfg_pkg::data_t'(shifted[7:0]);
      mem_txn_pkg::SIZE_HALF: sel_data = mem_cfg_pkg::data_t'(shifted[15:0]);
      default:                sel_data = rd_data;  // full word
    endcase
  end

  // response register, second edge after decode
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= en_q;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (en_q) begin
      rsp_data <= sel_data;  // held between responses
    end
  end

endmodule

`default_nettype wire

//--- memory_dp.sv
//////////////////////////////
// one-read one-write RAM, per-byte write enables
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memory_dp #(
  parameter int ADDR_W = 10
) (
  input  wire                rd_clk,   // drives both ports
  input  mem_cfg_pkg::be_t   wr_be,
  input  wire [ADDR_W-1:0]   wr_addr,
  input  mem_cfg_pkg::data_t wr_data,
  mem_rd_if.ram              rd,
  output mem_cfg_pkg::data_t rd_data
);

  localparam int DEPTH = 1 << ADDR_W;

  mem_cfg_pkg::data_t ram_word;  // addressed word, before the read register

  //////////////////////////////
  // byte lanes
  //////////////////////////////

  // each lane is its own byte-wide array
  for (genvar i = 0; i < mem_cfg_pkg::BE_W; i++) begin : g_lane
    logic [7:0] lane_mem [DEPTH];  // no reset, contents undefined at start

    always_ff @(posedge rd_clk) begin
      if (wr_be[i]) begin
        lane_mem[wr_addr] <= wr_data[i*8 +: 8];  // commit on the cycle after decode
      end
    end

    assign ram_word[i*8 +: 8] = lane_mem[rd.rd_addr];
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // holds the last word when idle
  always_ff @(posedge rd_clk) begin
    if (rd.rd_en) begin
      rd_data <= ram_word;
    end
  end

endmodule

`default_nettype wire

//--- mem_req_decode.sv
//////////////////////////////
// request decoder: size and alignment check,
// byte enables, lane replication, port steering
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_req_decode #(
  parameter int ADDR_W = 10
) (
  input  wire                       rd_clk,
  input  wire                       rst_n,
  input  wire                       req_valid,  // single-cycle strobe
  input  wire                       req_write,  // 1 write, 0 read
  input  wire [ADDR_W+1:0]          req_addr,   // byte address
  input  mem_txn_pkg::size_t        req_size,
  input  mem_cfg_pkg::data_t        req_wdata,
  output logic                      req_err,
  output mem_cfg_pkg::be_t          wr_be,
  output logic [ADDR_W-1:0]         wr_addr,
  output mem_cfg_pkg::data_t        wr_data,
  mem_rd_if.decode                  rd
);

  //////////////////////////////
  // address split
  //////////////////////////////

  logic [ADDR_W-1:0]    word_addr;
  mem_txn_pkg::offset_t req_off;

  assign word_addr = req_addr[ADDR_W+1:2];
  assign req_off   = req_addr[1:0];

  //////////////////////////////
  // classify and build lanes
  //////////////////////////////

  logic               legal;
  mem_cfg_pkg::be_t   be;
  mem_cfg_pkg::data_t lane_data;

  always_comb begin
    legal     = 1'b0;
    be        = '0;
    lane_data = req_wdata;
    case (req_size)
      mem_txn_pkg::SIZE_BYTE: begin
        legal     = 1'b1;                            // every offset is fine
        be        = mem_cfg_pkg::be_t'(1) << req_off;
        lane_data = {4{req_wdata[7:0]}};             // low byte on all lanes
      end
      mem_txn_pkg::SIZE_HALF: begin
        legal     = ~req_off[0];                     // even offsets only
        be        = mem_cfg_pkg::be_t'(3) << req_off;
        lane_data = {2{req_wdata[15:0]}};
      end
      mem_txn_pkg::SIZE_WORD: begin
        legal     = (req_off == 2'd0);
        be        = '1;
      end
      default: legal = 1'b0;                         // reserved size
    endcase
  end

  //////////////////////////////
  // registered outputs
  //////////////////////////////

  // strobes, mutually exclusive
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      req_err  <= 1'b0;
      wr_be    <= '0;
      rd.rd_en <= 1'b0;
    end else begin
      req_err  <= req_valid & ~legal;
      wr_be    <= (req_valid & legal & req_write) ? be : '0;
      rd.rd_en <= req_valid & legal & ~req_write;
    end
  end

  // payload, only meaningful next to a strobe
  always_ff @(posedge rd_clk) begin
    if (req_valid) begin
      wr_addr      <= word_addr;
      wr_data      <= lane_data;
      rd.rd_addr   <= word_addr;   // same word address for either port
      rd.rd_size   <= req_size;
      rd.rd_offset <= req_off;
    end
  end

endmodule

`default_nettype wire

//--- mem_rd_if.sv
//////////////////////////////
// read request bundle: decoder to RAM and aligner
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if #(
  parameter int ADDR_W = 10
);

  logic                 rd_en;      // one-cycle read strobe
  logic [ADDR_W-1:0]    rd_addr;    // word address
  mem_txn_pkg::size_t   rd_size;    // sideband for the aligner
  mem_txn_pkg::offset_t rd_offset;  // byte offset in the word

  // decoder owns the whole bundle
  modport decode (output rd_en, rd_addr, rd_size, rd_offset);

  modport ram    (input rd_en, rd_addr);             // address side only
  modport align  (input rd_en, rd_size, rd_offset);  // lane select side only

endinterface

`default_nettype wire

//--- mem_txn_pkg.sv
//////////////////////////////
// access-size encoding and byte offset type
//////////////////////////////

`default_nettype none

package mem_txn_pkg;

  //////////////////////////////
  // access size
  //////////////////////////////

  typedef logic [1:0] size_t;

  localparam size_t SIZE_BYTE = 2'd0;  // 8 bit, any offset
  localparam size_t SIZE_HALF = 2'd1;  // 16 bit, even offset only
  localparam size_t SIZE_WORD = 2'd2;  // 32 bit, offset 0 only
  // 2'd3 reserved, always rejected by the decoder

  //////////////////////////////
  // position within a word
  //////////////////////////////

  // low two bits of the byte address
  typedef logic [1:0] offset_t;

endpackage

`default_nettype wire

//--- mem_cfg_pkg.sv
//////////////////////////////
// data-path widths and shared vector types
//////////////////////////////

`default_nettype none

package mem_cfg_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int DATA_W = 32;         // fixed, lane logic assumes four bytes
  localparam int BE_W   = DATA_W / 8; // one enable per byte lane

  //////////////////////////////
  // vector types
  //////////////////////////////

  // one RAM word, also the host data bus
  typedef logic [DATA_W-1:0] data_t;

  typedef logic [BE_W-1:0]   be_t;    // per-lane write enables

endpackage

`default_nettype wire
